// ==== src/ex_pkg.sv ====
package ex_pkg;

  // micro-op opcodes seen by the execute stage
  typedef enum logic [3:0] {
    OP_ADD     = 4'd0,
    OP_SUB     = 4'd1,
    OP_AND     = 4'd2,
    OP_OR      = 4'd3,
    OP_XOR     = 4'd4,
    OP_SHL     = 4'd5,
    OP_SHR     = 4'd6,
    OP_MOV     = 4'd7,
    OP_CMP     = 4'd8,
    OP_CMPXCHG = 4'd9
  } ex_op_e;

  // register file geometry
  parameter int NUM_GPR = 8;
  parameter int GPR_AW  = 3;

  // accumulator, implicit operand of cmpxchg
  parameter logic [GPR_AW-1:0] EAX_IDX = 3'd0;

  // flags word layout
  parameter int FLAGS_W = 4;
  parameter int FLAG_CF = 0;
  parameter int FLAG_ZF = 1;
  parameter int FLAG_SF = 2;
  parameter int FLAG_OF = 3;

endpackage

// ==== src/uop_if.sv ====
`timescale 1ns/10ps

interface uop_if #(
  parameter int DATA_W = 32
);

  logic                      valid;
  ex_pkg::ex_op_e            op;
  logic [ex_pkg::GPR_AW-1:0] dreg;
  // destination value, source or immediate, eax
  logic [DATA_W-1:0]         val_a;
  logic [DATA_W-1:0]         val_b;
  logic [DATA_W-1:0]         val_c;

  modport issue (
    output valid, op, dreg, val_a, val_b, val_c
  );

  modport exec (
    input valid, op, dreg, val_a, val_b, val_c
  );

endinterface

// ==== src/ex_result_if.sv ====
`timescale 1ns/10ps

interface ex_result_if #(
  parameter int DATA_W = 32
);

  logic                       valid;
  logic                       ld_gpr1;
  logic [ex_pkg::GPR_AW-1:0]  dreg1;
  logic [DATA_W-1:0]          result1;
  // second write port always targets eax
  logic                       ld_gpr2;
  logic [DATA_W-1:0]          result2;
  logic                       ld_flags;
  logic [ex_pkg::FLAGS_W-1:0] flags;

  modport source (
    output valid, ld_gpr1, dreg1, result1, ld_gpr2, result2, ld_flags, flags
  );

  modport sink (
    input valid, ld_gpr1, dreg1, result1, ld_gpr2, result2, ld_flags, flags
  );

  modport monitor (
    input valid, ld_gpr1, dreg1, ld_gpr2
  );

endinterface

// ==== src/operand_issue.sv ====
`timescale 1ns/10ps

module operand_issue #(
  parameter int DATA_W = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  ex_pkg::ex_op_e            in_op,
  input  logic [ex_pkg::GPR_AW-1:0] in_dreg,
  input  logic [ex_pkg::GPR_AW-1:0] in_sreg,
  input  logic [DATA_W-1:0]         in_imm,
  input  logic                      in_use_imm,
  input  logic                      wb_stall,
  output logic                      in_ready,
  output logic [ex_pkg::GPR_AW-1:0] rd_addr_a,
  output logic [ex_pkg::GPR_AW-1:0] rd_addr_b,
  input  logic [DATA_W-1:0]         rd_data_a,
  input  logic [DATA_W-1:0]         rd_data_b,
  input  logic [DATA_W-1:0]         rd_data_c,
  uop_if.issue                      uop,
  ex_result_if.monitor              pend
);

  logic                      ex_valid;
  ex_pkg::ex_op_e            ex_op;
  logic [ex_pkg::GPR_AW-1:0] ex_dreg;
  logic [DATA_W-1:0]         ex_val_a;
  logic [DATA_W-1:0]         ex_val_b;
  logic [DATA_W-1:0]         ex_val_c;
  logic                      ex_ld1;
  logic                      ex_ld2;
  logic                      hit_a;
  logic                      hit_b;
  logic                      hit_c;
  logic                      accept;

  // true when a pending write lands on register r
  function automatic logic reg_busy(input logic ld1, input logic [ex_pkg::GPR_AW-1:0] d1,
                                    input logic ld2, input logic [ex_pkg::GPR_AW-1:0] r);
    return (ld1 && d1 == r) || (ld2 && r == ex_pkg::EAX_IDX);
  endfunction

  assign rd_addr_a = in_dreg;
  assign rd_addr_b = in_sreg;

  // cmpxchg in EX may write either dreg or eax, assume both
  assign ex_ld1 = ex_valid && ex_op != ex_pkg::OP_CMP;
  assign ex_ld2 = ex_valid && ex_op == ex_pkg::OP_CMPXCHG;

  assign hit_a = in_op != ex_pkg::OP_MOV &&
                 (reg_busy(ex_ld1, ex_dreg, ex_ld2, in_dreg) ||
                  reg_busy(pend.ld_gpr1, pend.dreg1, pend.ld_gpr2, in_dreg));
  assign hit_b = !in_use_imm &&
                 (reg_busy(ex_ld1, ex_dreg, ex_ld2, in_sreg) ||
                  reg_busy(pend.ld_gpr1, pend.dreg1, pend.ld_gpr2, in_sreg));
  assign hit_c = in_op == ex_pkg::OP_CMPXCHG &&
                 (reg_busy(ex_ld1, ex_dreg, ex_ld2, ex_pkg::EAX_IDX) ||
                  reg_busy(pend.ld_gpr1, pend.dreg1, pend.ld_gpr2, ex_pkg::EAX_IDX));

  assign in_ready = !wb_stall && !(hit_a || hit_b || hit_c);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (accept) begin
      ex_valid <= 1'b1;
    end else if (!wb_stall) begin
      ex_valid <= 1'b0;
    end
  end

  // EX latch payload
  always_ff @(posedge clk) begin
    if (accept) begin
      ex_op    <= in_op;
      ex_dreg  <= in_dreg;
      ex_val_a <= rd_data_a;
      ex_val_b <= in_use_imm ? in_imm : rd_data_b;
      ex_val_c <= rd_data_c;
    end
  end

  assign uop.valid = ex_valid;
  assign uop.op    = ex_op;
  assign uop.dreg  = ex_dreg;
  assign uop.val_a = ex_val_a;
  assign uop.val_b = ex_val_b;
  assign uop.val_c = ex_val_c;

endmodule

// ==== src/alu32.sv ====
`timescale 1ns/10ps

module alu32 #(
  parameter int DATA_W = 32
) (
  input  ex_pkg::ex_op_e             op,
  input  logic [DATA_W-1:0]          a,
  input  logic [DATA_W-1:0]          b,
  output logic [DATA_W-1:0]          result,
  output logic [ex_pkg::FLAGS_W-1:0] flags_out
);

  localparam int MSB  = DATA_W - 1;
  localparam int SH_W = $clog2(DATA_W);

  logic [SH_W-1:0] sh;
  logic [DATA_W:0] sum_ext;
  logic [DATA_W:0] diff_ext;
  logic [DATA_W:0] shl_ext;
  logic [DATA_W:0] shr_ext;
  logic            cf;
  logic            of;

  assign sh       = b[SH_W-1:0];
  assign sum_ext  = {1'b0, a} + {1'b0, b};
  // top bit is the borrow
  assign diff_ext = {1'b0, a} - {1'b0, b};
  // extra bit catches the last bit shifted out
  assign shl_ext  = {1'b0, a} << sh;
  assign shr_ext  = {a, 1'b0} >> sh;

  always_comb begin
    result = b;
    cf     = 1'b0;
    of     = 1'b0;
    case (op)
      ex_pkg::OP_ADD: begin
        result = sum_ext[MSB:0];
        cf     = sum_ext[DATA_W];
        of     = (a[MSB] == b[MSB]) && (sum_ext[MSB] != a[MSB]);
      end
      ex_pkg::OP_SUB, ex_pkg::OP_CMP, ex_pkg::OP_CMPXCHG: begin
        result = diff_ext[MSB:0];
        cf     = diff_ext[DATA_W];
        of     = (a[MSB] != b[MSB]) && (diff_ext[MSB] != a[MSB]);
      end
      ex_pkg::OP_AND: result = a & b;
      ex_pkg::OP_OR:  result = a | b;
      ex_pkg::OP_XOR: result = a ^ b;
      ex_pkg::OP_SHL: begin
        result = shl_ext[MSB:0];
        cf     = shl_ext[DATA_W];
        of     = shl_ext[MSB] ^ shl_ext[DATA_W];
      end
      ex_pkg::OP_SHR: begin
        result = shr_ext[DATA_W:1];
        cf     = shr_ext[0];
        of     = a[MSB];
      end
      default: result = b;
    endcase
  end

  always_comb begin
    flags_out                 = '0;
    flags_out[ex_pkg::FLAG_CF] = cf;
    flags_out[ex_pkg::FLAG_ZF] = (result == '0);
    flags_out[ex_pkg::FLAG_SF] = result[MSB];
    flags_out[ex_pkg::FLAG_OF] = of;
  end

endmodule

// ==== src/execute.sv ====
`timescale 1ns/10ps

module execute #(
  parameter int DATA_W = 32
) (
  uop_if.exec         uop,
  ex_result_if.source res
);

  localparam int SH_W = $clog2(DATA_W);

  logic [DATA_W-1:0]          alu_a;
  logic [DATA_W-1:0]          alu_b;
  logic [DATA_W-1:0]          alu_result;
  logic [ex_pkg::FLAGS_W-1:0] alu_flags;
  logic                       is_cx;
  logic                       is_shift;
  logic                       cx_equal;

  assign is_cx    = uop.op == ex_pkg::OP_CMPXCHG;
  assign is_shift = uop.op == ex_pkg::OP_SHL || uop.op == ex_pkg::OP_SHR;

  // cmpxchg compares eax against the destination
  assign alu_a = is_cx ? uop.val_c : uop.val_a;
  assign alu_b = is_cx ? uop.val_a : uop.val_b;

  alu32 #(
    .DATA_W (DATA_W)
  ) u_alu32 (
    .op        (uop.op),
    .a         (alu_a),
    .b         (alu_b),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  assign cx_equal = alu_flags[ex_pkg::FLAG_ZF];

  assign res.valid   = uop.valid;
  assign res.ld_gpr1 = uop.valid && uop.op != ex_pkg::OP_CMP && (!is_cx || cx_equal);
  // mismatch loads the destination value into eax
  assign res.ld_gpr2 = uop.valid && is_cx && !cx_equal;
  // zero shift count keeps the old flags
  assign res.ld_flags = uop.valid && uop.op != ex_pkg::OP_MOV &&
                        !(is_shift && uop.val_b[SH_W-1:0] == '0);

  assign res.dreg1   = uop.dreg;
  assign res.result1 = (uop.op == ex_pkg::OP_MOV || is_cx) ? uop.val_b : alu_result;
  assign res.result2 = uop.val_a;
  assign res.flags   = alu_flags;

endmodule

// ==== src/wb_latch.sv ====
`timescale 1ns/10ps

module wb_latch #(
  parameter int DATA_W = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_stall,
  ex_result_if.sink   ex_res,
  ex_result_if.source wb_res
);

  logic                       held_valid;
  logic                       ld_gpr1;
  logic                       ld_gpr2;
  logic                       ld_flags;
  logic [ex_pkg::GPR_AW-1:0]  dreg1;
  logic [DATA_W-1:0]          result1;
  logic [DATA_W-1:0]          result2;
  logic [ex_pkg::FLAGS_W-1:0] flags;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
      ld_gpr1    <= 1'b0;
      ld_gpr2    <= 1'b0;
      ld_flags   <= 1'b0;
    end else if (!wb_stall) begin
      held_valid <= ex_res.valid;
      ld_gpr1    <= ex_res.ld_gpr1;
      ld_gpr2    <= ex_res.ld_gpr2;
      ld_flags   <= ex_res.ld_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (!wb_stall) begin
      dreg1   <= ex_res.dreg1;
      result1 <= ex_res.result1;
      result2 <= ex_res.result2;
      flags   <= ex_res.flags;
    end
  end

  // held entry commits only once the stall drops
  assign wb_res.valid    = held_valid && !wb_stall;
  assign wb_res.ld_gpr1  = ld_gpr1;
  assign wb_res.dreg1    = dreg1;
  assign wb_res.result1  = result1;
  assign wb_res.ld_gpr2  = ld_gpr2;
  assign wb_res.result2  = result2;
  assign wb_res.ld_flags = ld_flags;
  assign wb_res.flags    = flags;

endmodule

// ==== src/writeback.sv ====
`timescale 1ns/10ps

module writeback #(
  parameter int DATA_W = 32
) (
  input  logic                       clk,
  input  logic                       rst_n,
  ex_result_if.sink                  wb_res,
  input  logic [ex_pkg::GPR_AW-1:0]  rd_addr_a,
  input  logic [ex_pkg::GPR_AW-1:0]  rd_addr_b,
  output logic [DATA_W-1:0]          rd_data_a,
  output logic [DATA_W-1:0]          rd_data_b,
  output logic [DATA_W-1:0]          rd_data_c,
  output logic                       commit_valid,
  output logic [ex_pkg::GPR_AW-1:0]  commit_dreg1,
  output logic                       commit_ld_gpr1,
  output logic [DATA_W-1:0]          commit_result1,
  output logic                       commit_ld_gpr2,
  output logic [DATA_W-1:0]          commit_result2,
  output logic                       commit_ld_flags,
  output logic [ex_pkg::FLAGS_W-1:0] commit_flags
);

  logic [DATA_W-1:0]          gpr [ex_pkg::NUM_GPR];
  logic [ex_pkg::FLAGS_W-1:0] flags_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ex_pkg::NUM_GPR; i++) begin
        gpr[i] <= '0;
      end
      flags_q <= '0;
    end else if (wb_res.valid) begin
      if (wb_res.ld_gpr2) begin
        gpr[ex_pkg::EAX_IDX] <= wb_res.result2;
      end
      // port 1 written last so it wins on eax
      if (wb_res.ld_gpr1) begin
        gpr[wb_res.dreg1] <= wb_res.result1;
      end
      if (wb_res.ld_flags) begin
        flags_q <= wb_res.flags;
      end
    end
  end

  assign rd_data_a = gpr[rd_addr_a];
  assign rd_data_b = gpr[rd_addr_b];
  assign rd_data_c = gpr[ex_pkg::EAX_IDX];

  assign commit_valid    = wb_res.valid;
  assign commit_dreg1    = wb_res.dreg1;
  assign commit_ld_gpr1  = wb_res.valid && wb_res.ld_gpr1;
  assign commit_result1  = wb_res.result1;
  assign commit_ld_gpr2  = wb_res.valid && wb_res.ld_gpr2;
  assign commit_result2  = wb_res.result2;
  assign commit_ld_flags = wb_res.valid && wb_res.ld_flags;
  // flags as they stand after this commit
  assign commit_flags    = commit_ld_flags ? wb_res.flags : flags_q;

endmodule

// ==== src/x86_ex_pipe.sv ====
`timescale 1ns/10ps

module x86_ex_pipe #(
  parameter int DATA_W = 32
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  ex_pkg::ex_op_e             in_op,
  input  logic [ex_pkg::GPR_AW-1:0]  in_dreg,
  input  logic [ex_pkg::GPR_AW-1:0]  in_sreg,
  input  logic [DATA_W-1:0]          in_imm,
  input  logic                       in_use_imm,
  input  logic                       wb_stall,
  output logic                       in_ready,
  output logic                       commit_valid,
  output logic [ex_pkg::GPR_AW-1:0]  commit_dreg1,
  output logic                       commit_ld_gpr1,
  output logic [DATA_W-1:0]          commit_result1,
  output logic                       commit_ld_gpr2,
  output logic [DATA_W-1:0]          commit_result2,
  output logic                       commit_ld_flags,
  output logic [ex_pkg::FLAGS_W-1:0] commit_flags
);

  logic [ex_pkg::GPR_AW-1:0] rd_addr_a;
  logic [ex_pkg::GPR_AW-1:0] rd_addr_b;
  logic [DATA_W-1:0]         rd_data_a;
  logic [DATA_W-1:0]         rd_data_b;
  logic [DATA_W-1:0]         rd_data_c;

  uop_if       #(.DATA_W(DATA_W)) uop_bus ();
  ex_result_if #(.DATA_W(DATA_W)) ex_bus ();
  ex_result_if #(.DATA_W(DATA_W)) wb_bus ();

  operand_issue #(
    .DATA_W (DATA_W)
  ) u_operand_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_dreg    (in_dreg),
    .in_sreg    (in_sreg),
    .in_imm     (in_imm),
    .in_use_imm (in_use_imm),
    .wb_stall   (wb_stall),
    .in_ready   (in_ready),
    .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .rd_data_c  (rd_data_c),
    .uop        (uop_bus.issue),
    .pend       (wb_bus.monitor)
  );

  execute #(
    .DATA_W (DATA_W)
  ) u_execute (
    .uop (uop_bus.exec),
    .res (ex_bus.source)
  );

  wb_latch #(
    .DATA_W (DATA_W)
  ) u_wb_latch (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_stall (wb_stall),
    .ex_res   (ex_bus.sink),
    .wb_res   (wb_bus.source)
  );

  writeback #(
    .DATA_W (DATA_W)
  ) u_writeback (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_res          (wb_bus.sink),
    .rd_addr_a       (rd_addr_a),
    .rd_addr_b       (rd_addr_b),
    .rd_data_a       (rd_data_a),
    .rd_data_b       (rd_data_b),
    .rd_data_c       (rd_data_c),
    .commit_valid    (commit_valid),
    .commit_dreg1    (commit_dreg1),
    .commit_ld_gpr1  (commit_ld_gpr1),
    .commit_result1  (commit_result1),
    .commit_ld_gpr2  (commit_ld_gpr2),
    .commit_result2  (commit_result2),
    .commit_ld_flags (commit_ld_flags),
    .commit_flags    (commit_flags)
  );

endmodule

// ==== verification/x86_ex_pipe_properties.sv ====
`timescale 1ns/10ps

module x86_ex_pipe_properties (
  input logic clk,
  input logic rst_n,
  input logic wb_stall,
  input logic in_ready,
  input logic commit_valid
);

  // a held WB entry never commits
  commit_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stall |-> !commit_valid)
    else $error("commit_valid high while wb_stall is high");

  reset_quiet: assert property (@(posedge clk) !rst_n |=> !commit_valid)
    else $error("commit seen in the cycle after reset");

  issue_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stall |-> !in_ready)
    else $error("in_ready high while wb_stall is high");

endmodule

bind x86_ex_pipe x86_ex_pipe_properties props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .wb_stall     (wb_stall),
  .in_ready     (in_ready),
  .commit_valid (commit_valid)
);

// ==== verification/x86_ex_pipe_tb.sv ====
`timescale 1ns/10ps

module x86_ex_pipe_tb;

  localparam int DATA_W     = 32;
  localparam int CLK_PERIOD = 40;
  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    logic [ex_pkg::GPR_AW-1:0]  dreg1;
    logic                       ld_gpr1;
    logic [DATA_W-1:0]          result1;
    logic                       ld_gpr2;
    logic [DATA_W-1:0]          result2;
    logic                       ld_flags;
    logic [ex_pkg::FLAGS_W-1:0] flags;
  } commit_t;

  logic                       clk;
  logic                       rst_n;
  logic                       in_valid;
  ex_pkg::ex_op_e             in_op;
  logic [ex_pkg::GPR_AW-1:0]  in_dreg;
  logic [ex_pkg::GPR_AW-1:0]  in_sreg;
  logic [DATA_W-1:0]          in_imm;
  logic                       in_use_imm;
  logic                       wb_stall;
  logic                       in_ready;
  logic                       commit_valid;
  logic [ex_pkg::GPR_AW-1:0]  commit_dreg1;
  logic                       commit_ld_gpr1;
  logic [DATA_W-1:0]          commit_result1;
  logic                       commit_ld_gpr2;
  logic [DATA_W-1:0]          commit_result2;
  logic                       commit_ld_flags;
  logic [ex_pkg::FLAGS_W-1:0] commit_flags;

  logic [DATA_W-1:0]          mdl_gpr [ex_pkg::NUM_GPR];
  logic [ex_pkg::FLAGS_W-1:0] mdl_flags;
  commit_t                    expected_q [$];
  logic                       stall_en;
  int                         cycles;
  int                         errors;
  int                         checks;
  int                         tests;
  int                         test_err_start;

  ex_pkg::ex_op_e alu_ops [7] = '{ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_AND,
                                  ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_SHL,
                                  ex_pkg::OP_SHR};
  ex_pkg::ex_op_e all_ops [10] = '{ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_AND,
                                   ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_SHL,
                                   ex_pkg::OP_SHR, ex_pkg::OP_MOV, ex_pkg::OP_CMP,
                                   ex_pkg::OP_CMPXCHG};

  x86_ex_pipe #(
    .DATA_W (DATA_W)
  ) dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .in_op           (in_op),
    .in_dreg         (in_dreg),
    .in_sreg         (in_sreg),
    .in_imm          (in_imm),
    .in_use_imm      (in_use_imm),
    .wb_stall        (wb_stall),
    .in_ready        (in_ready),
    .commit_valid    (commit_valid),
    .commit_dreg1    (commit_dreg1),
    .commit_ld_gpr1  (commit_ld_gpr1),
    .commit_result1  (commit_result1),
    .commit_ld_gpr2  (commit_ld_gpr2),
    .commit_result2  (commit_result2),
    .commit_ld_flags (commit_ld_flags),
    .commit_flags    (commit_flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x86 semantics applied to the model state, in acceptance order
  function automatic commit_t exp_commit(input ex_pkg::ex_op_e op,
                                         input logic [ex_pkg::GPR_AW-1:0] dreg,
                                         input logic [ex_pkg::GPR_AW-1:0] sreg,
                                         input logic [DATA_W-1:0] imm,
                                         input logic use_imm);
    commit_t           rec;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] r;
    logic [4:0]        n;
    longint            wide_s;
    longint            wide_u;
    logic              cf;
    logic              of;
    logic              upd;
    a   = mdl_gpr[dreg];
    b   = use_imm ? imm : mdl_gpr[sreg];
    n   = b[4:0];
    x   = (op == ex_pkg::OP_CMPXCHG) ? mdl_gpr[ex_pkg::EAX_IDX] : a;
    r   = b;
    cf  = 1'b0;
    of  = 1'b0;
    upd = 1'b1;
    case (op)
      ex_pkg::OP_ADD: begin
        r      = a + b;
        wide_u = longint'(a) + longint'(b);
        wide_s = longint'($signed(a)) + longint'($signed(b));
        cf     = wide_u > 64'h0000_0000_ffff_ffff;
        of     = wide_s != longint'($signed(r));
      end
      ex_pkg::OP_SUB, ex_pkg::OP_CMP, ex_pkg::OP_CMPXCHG: begin
        // cmpxchg compares eax against the destination
        if (op == ex_pkg::OP_CMPXCHG) b = a;
        r      = x - b;
        wide_s = longint'($signed(x)) - longint'($signed(b));
        cf     = x < b;
        of     = wide_s != longint'($signed(r));
        if (op == ex_pkg::OP_CMPXCHG) b = use_imm ? imm : mdl_gpr[sreg];
      end
      ex_pkg::OP_AND: r = a & b;
      ex_pkg::OP_OR:  r = a | b;
      ex_pkg::OP_XOR: r = a ^ b;
      ex_pkg::OP_SHL: begin
        r   = a << n;
        upd = n != 5'd0;
        // 0 - n wraps to 32 - n, the last bit moved out
        cf  = a[5'd0 - n];
        of  = r[DATA_W-1] ^ cf;
      end
      ex_pkg::OP_SHR: begin
        r   = a >> n;
        upd = n != 5'd0;
        cf  = a[n - 5'd1];
        of  = a[DATA_W-1];
      end
      default: upd = 1'b0;
    endcase
    rec          = '0;
    rec.dreg1    = dreg;
    rec.ld_flags = upd;
    rec.ld_gpr1  = op != ex_pkg::OP_CMP && (op != ex_pkg::OP_CMPXCHG || r == '0);
    rec.result1  = (op == ex_pkg::OP_MOV || op == ex_pkg::OP_CMPXCHG) ? b : r;
    rec.ld_gpr2  = op == ex_pkg::OP_CMPXCHG && r != '0;
    rec.result2  = a;
    if (rec.ld_gpr2) mdl_gpr[ex_pkg::EAX_IDX] = a;
    if (rec.ld_gpr1) mdl_gpr[dreg] = rec.result1;
    if (upd) begin
      mdl_flags                 = '0;
      mdl_flags[ex_pkg::FLAG_CF] = cf;
      mdl_flags[ex_pkg::FLAG_ZF] = r == '0;
      mdl_flags[ex_pkg::FLAG_SF] = r[DATA_W-1];
      mdl_flags[ex_pkg::FLAG_OF] = of;
    end
    rec.flags = mdl_flags;
    return rec;
  endfunction

  function automatic logic [DATA_W-1:0] pick_imm();
    // small values exercise shift counts, zero included
    if ($urandom % 3 == 0) return $urandom % 40;
    return $urandom;
  endfunction

  task automatic check_field(input string name, input logic [DATA_W-1:0] exp_val,
                             input logic [DATA_W-1:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
      errors++;
    end
  endtask

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_uop(input ex_pkg::ex_op_e op, input logic [ex_pkg::GPR_AW-1:0] dreg,
                           input logic [ex_pkg::GPR_AW-1:0] sreg,
                           input logic [DATA_W-1:0] imm, input logic use_imm);
    bit taken;
    taken      = 1'b0;
    in_valid   = 1'b1;
    in_op      = op;
    in_dreg    = dreg;
    in_sreg    = sreg;
    in_imm     = imm;
    in_use_imm = use_imm;
    while (!taken) begin
      #10;
      if (in_ready) begin
        expected_q.push_back(exp_commit(op, dreg, sreg, imm, use_imm));
        taken = 1'b1;
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (expected_q.size() != 0) @(negedge clk);
    tests++;
    if (errors == test_err_start) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - test_err_start);
    test_err_start = errors;
  endtask

  // random write-back back-pressure
  initial begin
    wb_stall = 1'b0;
    forever begin
      @(negedge clk);
      wb_stall = stall_en && ($urandom % 4 == 0);
    end
  end

  always @(negedge clk) begin : compare_commits
    commit_t exp_rec;
    #10;
    if (rst_n && commit_valid) begin
      assert (expected_q.size() != 0) else begin
        $display("unexpected commit at %0t with no micro-op outstanding", $time);
        errors++;
      end
      if (expected_q.size() != 0) begin
        exp_rec = expected_q.pop_front();
        check_field("commit_ld_gpr1", 32'(exp_rec.ld_gpr1), 32'(commit_ld_gpr1));
        check_field("commit_ld_gpr2", 32'(exp_rec.ld_gpr2), 32'(commit_ld_gpr2));
        check_field("commit_ld_flags", 32'(exp_rec.ld_flags), 32'(commit_ld_flags));
        check_field("commit_flags", 32'(exp_rec.flags), 32'(commit_flags));
        if (exp_rec.ld_gpr1) begin
          check_field("commit_dreg1", 32'(exp_rec.dreg1), 32'(commit_dreg1));
          check_field("commit_result1", exp_rec.result1, commit_result1);
        end
        if (exp_rec.ld_gpr2) check_field("commit_result2", exp_rec.result2, commit_result2);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d commits still outstanding",
             MAX_CYCLES, expected_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h8e24_a839));
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_op          = ex_pkg::OP_MOV;
    in_dreg        = '0;
    in_sreg        = '0;
    in_imm         = '0;
    in_use_imm     = 1'b0;
    stall_en       = 1'b0;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    test_err_start = 0;
    mdl_flags      = '0;
    for (int i = 0; i < ex_pkg::NUM_GPR; i++) mdl_gpr[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < ex_pkg::NUM_GPR; r++) begin
      issue_uop(ex_pkg::OP_MOV, 3'(r), 3'd0, $urandom, 1'b1);
    end
    finish_test("mov immediate");

    repeat (60) begin
      issue_uop(alu_ops[3'($urandom % 7)], 3'($urandom), 3'($urandom), pick_imm(),
                1'($urandom));
    end
    finish_test("random alu");

    issue_uop(ex_pkg::OP_CMP, 3'd1, 3'd2, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_CMP, 3'd3, 3'd0, mdl_gpr[3], 1'b1);
    issue_uop(ex_pkg::OP_CMP, 3'd4, 3'd0, mdl_gpr[4] + 32'd1, 1'b1);
    issue_uop(ex_pkg::OP_CMP, 3'd5, 3'd5, 32'd0, 1'b0);
    finish_test("cmp flags only");

    issue_uop(ex_pkg::OP_MOV, ex_pkg::EAX_IDX, 3'd0, 32'h1234_5678, 1'b1);
    issue_uop(ex_pkg::OP_MOV, 3'd5, 3'd0, 32'h1234_5678, 1'b1);
    issue_uop(ex_pkg::OP_MOV, 3'd6, 3'd0, 32'h0bad_cafe, 1'b1);
    // equal, then unequal once r5 has changed
    issue_uop(ex_pkg::OP_CMPXCHG, 3'd5, 3'd6, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_CMPXCHG, 3'd5, 3'd6, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_CMPXCHG, 3'd7, 3'd0, 32'h55, 1'b1);
    issue_uop(ex_pkg::OP_CMPXCHG, ex_pkg::EAX_IDX, 3'd3, 32'd0, 1'b0);
    finish_test("cmpxchg");

    issue_uop(ex_pkg::OP_ADD, 3'd1, 3'd1, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_SUB, 3'd2, 3'd1, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_XOR, 3'd1, 3'd2, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_SHL, 3'd1, 3'd0, 32'd3, 1'b1);
    issue_uop(ex_pkg::OP_MOV, 3'd3, 3'd1, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_CMPXCHG, 3'd3, 3'd2, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_ADD, ex_pkg::EAX_IDX, 3'd3, 32'd0, 1'b0);
    issue_uop(ex_pkg::OP_OR, 3'd4, ex_pkg::EAX_IDX, 32'd0, 1'b0);
    finish_test("dependent chain");

    stall_en = 1'b1;
    repeat (80) begin
      issue_uop(all_ops[4'($urandom % 10)], 3'($urandom), 3'($urandom), pick_imm(),
                1'($urandom));
    end
    stall_en = 1'b0;
    finish_test("random stream with wb_stall");

    // window for any duplicated commit
    repeat (4) @(negedge clk);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== x86_ex_pipe.f ====
src/ex_pkg.sv
src/uop_if.sv
src/ex_result_if.sv
src/operand_issue.sv
src/alu32.sv
src/execute.sv
src/wb_latch.sv
src/writeback.sv
src/x86_ex_pipe.sv
verification/x86_ex_pipe_properties.sv
verification/x86_ex_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module x86_ex_pipe_tb -Mdir obj_dir -f x86_ex_pipe.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vx86_ex_pipe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
